/* Makefile */
SIM      := verilator
TOP      := tb_riscv_decode
FILELIST := src.f
FLAGS    := --binary --assert -j 0
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* design/ctrl_flow_decode.sv */
`timescale 1ns/1ps

module ctrl_flow_decode
(
   input  decode_pkg::insn_t    insn,
   input  logic                 pred_taken,
   output decode_pkg::dec_res_t res
);

   import decode_pkg::*;

   opcode_t    opc;
   reg_idx_t   rd;
   reg_idx_t   rs1;
   logic [2:0] funct3;
   logic       rs1_is_link;
   dec_res_t   dec;

   assign opc    = insn[6:0];
   assign rd     = insn[11:7];
   assign rs1    = insn[19:15];
   assign funct3 = insn[14:12];

   assign rs1_is_link = (rs1 == link_reg_a) || (rs1 == link_reg_b);

   always_comb
   begin
      dec = '0;
      case (opc)
         opc_branch:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.src_b_valid = 1'b1;
            dec.is_int      = 1'b1;
            dec.is_br       = 1'b1;
            dec.br_pred     = pred_taken;
            dec.imm_sel     = imm_sel_pc;
            case (funct3)
               3'd0: dec.op = BEQ;
               3'd1: dec.op = BNE;
               3'd4: dec.op = BLT;
               3'd5: dec.op = BGE;
               3'd6: dec.op = BLTU;
               3'd7: dec.op = BGEU;
               default:
               begin
                  dec       = '0; // funct3 2 and 3 are reserved
                  dec.match = 1'b1;
                  dec.op    = II;
               end
            endcase
         end
         opc_jal:
         begin
            dec.match     = 1'b1;
            dec.op        = (rd == '0) ? J : JAL;
            dec.dst_valid = (rd != '0);
            dec.is_int    = 1'b1;
            dec.is_br     = 1'b1;
            dec.br_pred   = 1'b1; // always taken
            dec.imm_sel   = imm_sel_pc;
         end
         opc_jalr:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.is_int      = 1'b1;
            dec.is_br       = 1'b1;
            dec.br_pred     = 1'b1;
            dec.imm_sel     = imm_sel_i;
            if (rd == '0)
               dec.op = rs1_is_link ? RET : JR;
            else
            begin
               dec.op        = JALR;
               dec.dst_valid = 1'b1;
            end
         end
         default:
         begin
         end
      endcase
   end

   assign res = dec;

endmodule

/* design/decode_pkg.sv */
package decode_pkg;

   typedef logic [63:0] xlen_t;
   typedef logic [31:0] insn_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [2:0]  imm_sel_t;

   // major opcodes in insn[6:0]
   localparam opcode_t opc_load   = 7'h03;
   localparam opcode_t opc_store  = 7'h23;
   localparam opcode_t opc_op_imm = 7'h13;
   localparam opcode_t opc_op     = 7'h33;
   localparam opcode_t opc_lui    = 7'h37;
   localparam opcode_t opc_auipc  = 7'h17;
   localparam opcode_t opc_branch = 7'h63;
   localparam opcode_t opc_jal    = 7'h6f;
   localparam opcode_t opc_jalr   = 7'h67;

   // x1 (ra) and x5 (t0) act as link registers
   localparam reg_idx_t link_reg_a = 5'd1;
   localparam reg_idx_t link_reg_b = 5'd5;

   // immediate source in the micro-op
   localparam imm_sel_t imm_sel_none = 3'd0;
   localparam imm_sel_t imm_sel_i    = 3'd1;
   localparam imm_sel_t imm_sel_s    = 3'd2;
   localparam imm_sel_t imm_sel_u    = 3'd3;
   localparam imm_sel_t imm_sel_pc   = 3'd4; // pc + B/J/U offset

   typedef enum logic [5:0] {
      NOP, II, FETCH_PF, IRQ,
      LB, LH, LW, LD, LBU, LHU, LWU,
      SB, SH, SW, SD,
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
      SLLI, SRLI, SRAI, SEXTB, SEXTH,
      ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
      SH1ADD, SH2ADD, SH3ADD,
      CZEQZ, CZNEZ,
      LUI, AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET
   } uop_op_t;

   typedef struct packed {
      insn_t insn;
      xlen_t pc;
      logic  page_fault;
      logic  irq;
      logic  pred_taken;
   } fetch_t;

   typedef struct packed {
      logic     match;       // decoder owns this opcode
      uop_op_t  op;
      logic     src_a_valid;
      logic     src_b_valid;
      logic     dst_valid;
      logic     is_mem;
      logic     is_store;
      logic     is_int;
      logic     is_br;
      logic     br_pred;
      imm_sel_t imm_sel;
   } dec_res_t;

   typedef struct packed {
      xlen_t imm_i;
      xlen_t imm_s;
      xlen_t imm_u;
      xlen_t pc_sum;
   } imm_set_t;

   typedef struct packed {
      uop_op_t  op;
      reg_idx_t src_a;
      reg_idx_t src_b;
      reg_idx_t dst;
      logic     src_a_valid;
      logic     src_b_valid;
      logic     dst_valid;
      logic     is_mem;
      logic     is_store;
      logic     is_int;
      logic     is_br;
      logic     br_pred;
      xlen_t    imm;
      xlen_t    pc;
   } uop_t;

endpackage

/* design/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
(
   input  decode_pkg::insn_t    insn,
   input  decode_pkg::xlen_t    pc,
   output decode_pkg::imm_set_t imms
);

   import decode_pkg::*;

   opcode_t opc;
   xlen_t   imm_b;
   xlen_t   imm_j;
   xlen_t   imm_u;
   xlen_t   pc_off;

   assign opc = insn[6:0];

   assign imm_b = {{52{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

   assign imm_j = {{44{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

   assign imm_u = {{32{insn[31]}}, insn[31:12], 12'd0};

   // offset for the pc-relative forms
   always_comb
   begin
      case (opc)
         opc_branch: pc_off = imm_b;
         opc_jal:    pc_off = imm_j;
         default:    pc_off = imm_u; // auipc
      endcase
   end

   always_comb
   begin
      imms.imm_i  = {{52{insn[31]}}, insn[31:20]};
      imms.imm_s  = {{52{insn[31]}}, insn[31:25], insn[11:7]};
      imms.imm_u  = imm_u;
      imms.pc_sum = pc + pc_off; // wraps mod 2^64
   end

endmodule

/* design/int_op_decode.sv */
`timescale 1ns/1ps

module int_op_decode
(
   input  decode_pkg::insn_t    insn,
   output decode_pkg::dec_res_t res
);

   import decode_pkg::*;

   opcode_t  opc;
   reg_idx_t rd;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       illegal;
   dec_res_t   dec;

   assign opc    = insn[6:0];
   assign rd     = insn[11:7];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];

   always_comb
   begin
      dec     = '0;
      illegal = 1'b0;
      case (opc)
         opc_load:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.dst_valid   = 1'b1;
            dec.is_mem      = 1'b1;
            dec.imm_sel     = imm_sel_i;
            case (funct3)
               3'd0:    dec.op = LB;
               3'd1:    dec.op = LH;
               3'd2:    dec.op = LW;
               3'd3:    dec.op = LD;
               3'd4:    dec.op = LBU;
               3'd5:    dec.op = LHU;
               3'd6:    dec.op = LWU;
               default: illegal = 1'b1;
            endcase
         end
         opc_store:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.src_b_valid = 1'b1;
            dec.is_mem      = 1'b1;
            dec.is_store    = 1'b1;
            dec.imm_sel     = imm_sel_s;
            case (funct3)
               3'd0:    dec.op = SB;
               3'd1:    dec.op = SH;
               3'd2:    dec.op = SW;
               3'd3:    dec.op = SD;
               default: illegal = 1'b1;
            endcase
         end
         opc_op_imm:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.dst_valid   = 1'b1;
            dec.is_int      = 1'b1;
            dec.imm_sel     = imm_sel_i;
            case (funct3)
               3'd0: dec.op = ADDI;
               3'd1:
               begin
                  if (insn[31:20] == 12'h604)
                     dec.op = SEXTB;
                  else if (insn[31:20] == 12'h605)
                     dec.op = SEXTH;
                  else if (insn[31:26] == 6'h00)
                     dec.op = SLLI;
                  else
                     illegal = 1'b1;
               end
               3'd2: dec.op = SLTI;
               3'd3: dec.op = SLTIU;
               3'd4: dec.op = XORI;
               3'd5:
               begin
                  if (insn[31:26] == 6'h00)
                     dec.op = SRLI;
                  else if (insn[31:26] == 6'h10)
                     dec.op = SRAI;
                  else
                     illegal = 1'b1;
               end
               3'd6: dec.op = ORI;
               default: dec.op = ANDI;
            endcase
         end
         opc_op:
         begin
            dec.match       = 1'b1;
            dec.src_a_valid = 1'b1;
            dec.src_b_valid = 1'b1;
            dec.dst_valid   = 1'b1;
            dec.is_int      = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'd0}: dec.op = ADDU;
               {7'h20, 3'd0}: dec.op = SUBU;
               {7'h00, 3'd1}: dec.op = SLL;
               {7'h00, 3'd2}: dec.op = SLT;
               {7'h00, 3'd3}: dec.op = SLTU;
               {7'h00, 3'd4}: dec.op = XOR;
               {7'h00, 3'd5}: dec.op = SRL;
               {7'h20, 3'd5}: dec.op = SRA;
               {7'h00, 3'd6}: dec.op = OR;
               {7'h00, 3'd7}: dec.op = AND;
               {7'h01, 3'd0}: dec.op = MUL;
               {7'h01, 3'd1}: dec.op = MULH;
               {7'h01, 3'd3}: dec.op = MULHU;
               {7'h01, 3'd4}: dec.op = DIV;
               {7'h01, 3'd5}: dec.op = DIVU;
               {7'h01, 3'd6}: dec.op = REM;
               {7'h01, 3'd7}: dec.op = REMU;
               {7'h10, 3'd2}: dec.op = SH1ADD; // zba
               {7'h10, 3'd4}: dec.op = SH2ADD;
               {7'h10, 3'd6}: dec.op = SH3ADD;
               {7'h07, 3'd5}: dec.op = CZEQZ;  // zicond
               {7'h07, 3'd7}: dec.op = CZNEZ;
               default:       illegal = 1'b1;
            endcase
         end
         opc_lui:
         begin
            dec.match     = 1'b1;
            dec.op        = LUI;
            dec.dst_valid = 1'b1;
            dec.is_int    = 1'b1;
            dec.imm_sel   = imm_sel_u;
         end
         opc_auipc:
         begin
            dec.match     = 1'b1;
            dec.op        = AUIPC;
            dec.dst_valid = 1'b1;
            dec.is_int    = 1'b1;
            dec.imm_sel   = imm_sel_pc;
         end
         default:
         begin
         end
      endcase

      if (illegal)
      begin
         dec       = '0;
         dec.match = 1'b1;
         dec.op    = II;
      end
      else if (dec.dst_valid && rd == '0)
      begin
         dec.op        = NOP; // write to x0 is dropped
         dec.dst_valid = 1'b0;
      end
   end

   assign res = dec;

endmodule

/* design/riscv_decode.sv */
`timescale 1ns/1ps

module riscv_decode
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  decode_pkg::fetch_t fetch,
   output logic               out_valid,
   output decode_pkg::uop_t   uop
);

   import decode_pkg::*;

   imm_set_t imms;
   dec_res_t int_res;
   dec_res_t ctrl_res;

   imm_gen i_imm_gen (
      .insn (fetch.insn),
      .pc   (fetch.pc),
      .imms (imms)
   );

   int_op_decode i_int_op_decode (
      .insn (fetch.insn),
      .res  (int_res)
   );

   ctrl_flow_decode i_ctrl_flow_decode (
      .insn       (fetch.insn),
      .pred_taken (fetch.pred_taken),
      .res        (ctrl_res)
   );

   uop_stage i_uop_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .fetch     (fetch),
      .imms      (imms),
      .int_res   (int_res),
      .ctrl_res  (ctrl_res),
      .out_valid (out_valid),
      .uop       (uop)
   );

endmodule

/* design/uop_stage.sv */
`timescale 1ns/1ps

module uop_stage
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  decode_pkg::fetch_t   fetch,
   input  decode_pkg::imm_set_t imms,
   input  decode_pkg::dec_res_t int_res,
   input  decode_pkg::dec_res_t ctrl_res,
   output logic                 out_valid,
   output decode_pkg::uop_t     uop
);

   import decode_pkg::*;

   dec_res_t sel;
   uop_t     uop_d;

   always_comb
   begin
      if (int_res.match)
         sel = int_res;
      else if (ctrl_res.match)
         sel = ctrl_res;
      else
      begin
         sel    = '0; // opcode owned by nobody
         sel.op = II;
      end

      if (fetch.page_fault || fetch.irq)
      begin
         sel    = '0;
         sel.op = fetch.page_fault ? FETCH_PF : IRQ; // fault wins over irq
      end
   end

   always_comb
   begin
      uop_d.op          = sel.op;
      uop_d.src_a       = sel.src_a_valid ? fetch.insn[19:15] : '0;
      uop_d.src_b       = sel.src_b_valid ? fetch.insn[24:20] : '0;
      uop_d.dst         = sel.dst_valid ? fetch.insn[11:7] : '0;
      uop_d.src_a_valid = sel.src_a_valid;
      uop_d.src_b_valid = sel.src_b_valid;
      uop_d.dst_valid   = sel.dst_valid;
      uop_d.is_mem      = sel.is_mem;
      uop_d.is_store    = sel.is_store;
      uop_d.is_int      = sel.is_int;
      uop_d.is_br       = sel.is_br;
      uop_d.br_pred     = sel.br_pred;
      uop_d.pc          = fetch.pc;
      case (sel.imm_sel)
         imm_sel_i:  uop_d.imm = imms.imm_i;
         imm_sel_s:  uop_d.imm = imms.imm_s;
         imm_sel_u:  uop_d.imm = imms.imm_u;
         imm_sel_pc: uop_d.imm = imms.pc_sum;
         default:    uop_d.imm = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_valid <= 1'b0;
         uop       <= '0;
      end
      else
      begin
         out_valid <= in_valid;
         if (in_valid)
            uop <= uop_d; // held while idle
      end
   end

endmodule

/* src.f */
design/decode_pkg.sv
design/imm_gen.sv
design/int_op_decode.sv
design/ctrl_flow_decode.sv
design/uop_stage.sv
design/riscv_decode.sv
testbench/riscv_decode_props.sv
testbench/tb_riscv_decode.sv

/* testbench/riscv_decode_props.sv */
`timescale 1ns/1ps

module riscv_decode_props
(
   input logic             clk,
   input logic             rst_n,
   input logic             in_valid,
   input logic             out_valid,
   input decode_pkg::uop_t uop
);

   a_out_follows_in: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |=> out_valid)
   else $error("out_valid missing one cycle after in_valid");

   a_no_spurious_out: assert property (@(posedge clk) disable iff (!rst_n)
      !in_valid |=> !out_valid)
   else $error("out_valid high without a strobe");

   a_quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> !out_valid)
   else $error("out_valid high during reset");

   a_dst_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
      uop.dst_valid |-> uop.dst != 5'd0)
   else $error("dst_valid set with dst x0");

endmodule

bind riscv_decode riscv_decode_props i_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .uop       (uop)
);

/* testbench/tb_riscv_decode.sv */
`timescale 1ns/1ps

module tb_riscv_decode;

   import decode_pkg::*;

   localparam int unsigned seed        = 32'h22ecbc8e;
   localparam int          num_strobes = 5000;
   localparam int          drive_limit = 12000;
   localparam int          max_cycles  = 20000;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     in_valid;
   fetch_t   fetch;
   logic     out_valid;
   uop_t     uop;
   uop_t     pending[$]; // at most one item waiting for its output
   uop_t     held = '0;
   int       checked = 0;

   riscv_decode i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .fetch     (fetch),
      .out_valid (out_valid),
      .uop       (uop)
   );

   always #5 clk = ~clk;

   task automatic stop_with_error(string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "%s", what);
   endtask

   task automatic report_mismatch(string name, uop_t want, uop_t got);
      $display("Fail %s expected %s %h actual %s %h", name, want.op.name(), want,
               got.op.name(), got);
      stop_with_error("micro-op differs from the reference model");
   endtask

   function automatic reg_idx_t pick_reg();
      case ($urandom_range(0, 5))
         0:       return 5'd0;
         1:       return 5'd1;
         2:       return 5'd5;
         3:       return 5'd4; // sext.b/h rs2 field
         default: return reg_idx_t'($urandom);
      endcase
   endfunction

   function automatic logic [6:0] pick_funct7();
      case ($urandom_range(0, 5))
         0:       return 7'h00;
         1:       return 7'h20;
         2:       return 7'h01;
         3:       return 7'h10;
         4:       return 7'h07;
         default: return 7'h30;
      endcase
   endfunction

   function automatic insn_t rand_insn();
      insn_t w;
      w = $urandom;
      if ($urandom_range(0, 4) != 0) // mostly a kept opcode
      begin
         case ($urandom_range(0, 8))
            0:       w[6:0] = opc_load;
            1:       w[6:0] = opc_store;
            2:       w[6:0] = opc_op_imm;
            3:       w[6:0] = opc_op;
            4:       w[6:0] = opc_lui;
            5:       w[6:0] = opc_auipc;
            6:       w[6:0] = opc_branch;
            7:       w[6:0] = opc_jal;
            default: w[6:0] = opc_jalr;
         endcase
      end
      w[11:7]  = pick_reg();
      w[19:15] = pick_reg();
      w[24:20] = pick_reg();
      if ($urandom_range(0, 1) == 0)
         w[31:25] = pick_funct7();
      return w;
   endfunction

   function automatic fetch_t rand_fetch();
      fetch_t f;
      f.insn       = rand_insn();
      f.pc         = {$urandom, $urandom};
      f.page_fault = ($urandom_range(0, 49) == 0);
      f.irq        = ($urandom_range(0, 29) == 0);
      f.pred_taken = ($urandom_range(0, 1) == 1);
      return f;
   endfunction

   // reference model of the decoder
   function automatic uop_t expect_uop(fetch_t f);
      uop_t       u;
      logic [2:0] f3;
      logic [6:0] f7;
      reg_idx_t   rd;
      logic       bad;
      logic       writes;
      xlen_t      off_b;
      xlen_t      off_j;
      u      = '0;
      bad    = 1'b0;
      writes = 1'b0;
      f3     = f.insn[14:12];
      f7     = f.insn[31:25];
      rd     = f.insn[11:7];
      off_b  = xlen_t'($signed({f.insn[31], f.insn[7], f.insn[30:25], f.insn[11:8], 1'b0}));
      off_j  = xlen_t'($signed({f.insn[31], f.insn[19:12], f.insn[20], f.insn[30:21], 1'b0}));
      case (f.insn[6:0])
         opc_load:
         begin
            {u.src_a_valid, u.src_b_valid, u.dst_valid} = 3'b101;
            {u.is_mem, u.is_store, u.is_int, u.is_br} = 4'b1000;
            u.imm  = xlen_t'($signed(f.insn[31:20]));
            writes = 1'b1;
            case (f3)
               3'd0:    u.op = LB;
               3'd1:    u.op = LH;
               3'd2:    u.op = LW;
               3'd3:    u.op = LD;
               3'd4:    u.op = LBU;
               3'd5:    u.op = LHU;
               3'd6:    u.op = LWU;
               default: bad = 1'b1;
            endcase
         end
         opc_store:
         begin
            {u.src_a_valid, u.src_b_valid, u.dst_valid} = 3'b110;
            {u.is_mem, u.is_store, u.is_int, u.is_br} = 4'b1100;
            u.imm = xlen_t'($signed({f.insn[31:25], f.insn[11:7]}));
            case (f3)
               3'd0:    u.op = SB;
               3'd1:    u.op = SH;
               3'd2:    u.op = SW;
               3'd3:    u.op = SD;
               default: bad = 1'b1;
            endcase
         end
         opc_op_imm:
         begin
            {u.src_a_valid, u.src_b_valid, u.dst_valid} = 3'b101;
            u.is_int = 1'b1;
            u.imm    = xlen_t'($signed(f.insn[31:20]));
            writes   = 1'b1;
            case (f3)
               3'd0: u.op = ADDI;
               3'd1:
               begin
                  if (f.insn[31:20] == 12'h604)
                     u.op = SEXTB;
                  else if (f.insn[31:20] == 12'h605)
                     u.op = SEXTH;
                  else if (f.insn[31:26] == 6'b000000)
                     u.op = SLLI; // 6-bit shamt
                  else
                     bad = 1'b1;
               end
               3'd2: u.op = SLTI;
               3'd3: u.op = SLTIU;
               3'd4: u.op = XORI;
               3'd5:
               begin
                  if (f.insn[31:26] == 6'b000000)
                     u.op = SRLI;
                  else if (f.insn[31:26] == 6'b010000)
                     u.op = SRAI;
                  else
                     bad = 1'b1;
               end
               3'd6: u.op = ORI;
               3'd7: u.op = ANDI;
            endcase
         end
         opc_op:
         begin
            {u.src_a_valid, u.src_b_valid, u.dst_valid} = 3'b111;
            u.is_int = 1'b1;
            writes   = 1'b1;
            case ({f7, f3})
               {7'h00, 3'd0}: u.op = ADDU;
               {7'h20, 3'd0}: u.op = SUBU;
               {7'h00, 3'd1}: u.op = SLL;
               {7'h00, 3'd2}: u.op = SLT;
               {7'h00, 3'd3}: u.op = SLTU;
               {7'h00, 3'd4}: u.op = XOR;
               {7'h00, 3'd5}: u.op = SRL;
               {7'h20, 3'd5}: u.op = SRA;
               {7'h00, 3'd6}: u.op = OR;
               {7'h00, 3'd7}: u.op = AND;
               {7'h01, 3'd0}: u.op = MUL;
               {7'h01, 3'd1}: u.op = MULH;
               {7'h01, 3'd3}: u.op = MULHU;
               {7'h01, 3'd4}: u.op = DIV;
               {7'h01, 3'd5}: u.op = DIVU;
               {7'h01, 3'd6}: u.op = REM;
               {7'h01, 3'd7}: u.op = REMU;
               {7'h10, 3'd2}: u.op = SH1ADD;
               {7'h10, 3'd4}: u.op = SH2ADD;
               {7'h10, 3'd6}: u.op = SH3ADD;
               {7'h07, 3'd5}: u.op = CZEQZ;
               {7'h07, 3'd7}: u.op = CZNEZ;
               default:       bad = 1'b1;
            endcase
         end
         opc_lui, opc_auipc:
         begin
            u.dst_valid = 1'b1;
            u.is_int    = 1'b1;
            writes      = 1'b1;
            u.op        = (f.insn[6:0] == opc_lui) ? LUI : AUIPC;
            u.imm       = xlen_t'($signed({f.insn[31:12], 12'h000}));
            if (u.op == AUIPC)
               u.imm = f.pc + u.imm;
         end
         opc_branch:
         begin
            {u.src_a_valid, u.src_b_valid, u.dst_valid} = 3'b110;
            {u.is_mem, u.is_store, u.is_int, u.is_br} = 4'b0011;
            u.br_pred = f.pred_taken;
            u.imm     = f.pc + off_b;
            case (f3)
               3'd0:    u.op = BEQ;
               3'd1:    u.op = BNE;
               3'd4:    u.op = BLT;
               3'd5:    u.op = BGE;
               3'd6:    u.op = BLTU;
               3'd7:    u.op = BGEU;
               default: bad = 1'b1;
            endcase
         end
         opc_jal:
         begin
            {u.is_mem, u.is_store, u.is_int, u.is_br} = 4'b0011;
            u.br_pred   = 1'b1;
            u.dst_valid = (rd != 5'd0);
            u.op        = u.dst_valid ? JAL : J;
            u.imm       = f.pc + off_j;
         end
         opc_jalr:
         begin
            {u.is_mem, u.is_store, u.is_int, u.is_br} = 4'b0011;
            u.src_a_valid = 1'b1;
            u.br_pred     = 1'b1;
            u.dst_valid   = (rd != 5'd0);
            u.imm         = xlen_t'($signed(f.insn[31:20]));
            if (u.dst_valid)
               u.op = JALR;
            else if (f.insn[19:15] == 5'd1 || f.insn[19:15] == 5'd5)
               u.op = RET;
            else
               u.op = JR;
         end
         default: bad = 1'b1; // opcode outside the kept set
      endcase
      if (bad)
      begin
         u    = '0;
         u.op = II;
      end
      else if (writes && rd == 5'd0)
      begin
         u.op        = NOP;
         u.dst_valid = 1'b0;
      end
      if (f.page_fault || f.irq)
      begin
         u    = '0;
         u.op = f.page_fault ? FETCH_PF : IRQ;
      end
      u.src_a = u.src_a_valid ? f.insn[19:15] : 5'd0;
      u.src_b = u.src_b_valid ? f.insn[24:20] : 5'd0;
      u.dst   = u.dst_valid ? rd : 5'd0;
      u.pc    = f.pc;
      return u;
   endfunction

   // outputs are compared half a cycle after the edge
   always @(negedge clk)
   begin
      uop_t want;
      if (rst_n)
      begin
         if (out_valid)
         begin
            assert (pending.size() == 1)
            else stop_with_error("out_valid was raised without a strobe one cycle before");
            want = pending.pop_front();
            assert (uop === want)
            else report_mismatch("decode", want, uop);
            held = uop;
            checked++;
         end
         else
         begin
            assert (pending.size() == 0)
            else stop_with_error("out_valid did not follow a strobe one cycle later");
            assert (uop === held)
            else report_mismatch("idle hold", held, uop);
         end
         if (in_valid)
            pending.push_back(expect_uop(fetch));
      end
   end

   initial
   begin
      int cyc;
      for (cyc = 0; cyc < max_cycles; cyc++)
         @(posedge clk);
      stop_with_error("watchdog expired before the run finished");
   end

   initial
   begin
      int sent;
      int cyc;
      void'($urandom(seed));
      rst_n    = 1'b0;
      in_valid = 1'b0;
      fetch    = '0;
      sent     = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      repeat (3) @(posedge clk); // quiet cycles without output
      for (cyc = 0; sent < num_strobes; cyc++)
      begin
         if (cyc > drive_limit)
            stop_with_error("driver did not reach the strobe count in time");
         @(posedge clk);
         if ($urandom_range(0, 9) < 7)
         begin
            in_valid <= 1'b1;
            fetch    <= rand_fetch();
            sent++;
         end
         else
            in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b0;
      for (cyc = 0; checked < sent; cyc++)
      begin
         if (cyc > 10)
            stop_with_error("last micro-ops never appeared at the output");
         @(posedge clk);
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
